/* Bender.yml */
package:
  name: sim_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_pkg.sv
      - hdl/mem_req_issue.sv
      - hdl/req_fifo.sv
      - hdl/axi_rw_master.sv
      - hdl/sim_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/sim_top_asserts.sv
      - tests/tb_sim_top.sv

/* hdl/axi_pkg.sv */
`include "axi_settings.svh"

package axi_pkg;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE,                                    // 00: 1 byte
        SZ_HALF,                                    // 01: 2 bytes
        SZ_WORD,                                    // 10: 4 bytes
        SZ_DWORD                                    // 11: 8 bytes
    } acc_size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AR,
        ST_R,
        ST_AW_W,
        ST_B
    } master_state_e;

    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef struct packed {
        mem_op_e                      op;
        acc_size_e                    size;
        logic [`AXI_ADDR_WIDTH-1:0]   addr;         // Full byte address
        logic [`AXI_DATA_WIDTH-1:0]   wdata;        // Already in its byte lane
        logic [`AXI_STRB_WIDTH-1:0]   wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]     id;
        logic [`AXI_ADDR_WIDTH-1:0]   addr;
        logic [7:0]                   len;
        logic [2:0]                   size;
        logic [1:0]                   burst;
    } axi_ax_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]   data;
        logic [`AXI_STRB_WIDTH-1:0]   strb;
        logic                         last;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]     id;
        axi_resp_e                    resp;
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]     id;
        logic [`AXI_DATA_WIDTH-1:0]   data;
        axi_resp_e                    resp;
        logic                         last;
    } axi_r_t;

endpackage

/* hdl/axi_rw_master.sv */
`timescale 1ns/100ps
`include "axi_settings.svh"

module axi_rw_master import axi_pkg::*; (
    input  logic                         clock,
    input  logic                         reset_i,
    input  mem_req_t                     req_i,
    input  logic                         empty_i,
    output logic                         pop_o,
    output axi_ax_t                      aw_o,
    output logic                         aw_valid_o,
    input  logic                         aw_ready_i,
    output axi_w_t                       w_o,
    output logic                         w_valid_o,
    input  logic                         w_ready_i,
    input  axi_b_t                       b_i,
    input  logic                         b_valid_i,
    output logic                         b_ready_o,
    output axi_ax_t                      ar_o,
    output logic                         ar_valid_o,
    input  logic                         ar_ready_i,
    input  axi_r_t                       r_i,
    input  logic                         r_valid_i,
    output logic                         r_ready_o,
    output logic                         resp_valid_o,
    output logic [`AXI_DATA_WIDTH-1:0]   rdata_o,
    output axi_resp_e                    resp_o
);

    localparam int DW = `AXI_DATA_WIDTH;

    master_state_e               state_q;
    mem_req_t                    req_q;
    logic [`AXI_ID_WIDTH-1:0]    id_cnt_q;
    logic [`AXI_ID_WIDTH-1:0]    id_q;
    logic                        aw_done_q;
    logic                        w_done_q;
    logic                        resp_valid_q;
    logic [DW-1:0]               rdata_q;
    axi_resp_e                   resp_q;
    logic                        aw_fire;
    logic                        w_fire;
    logic                        r_fire;
    logic                        b_fire;
    axi_ax_t                     ax;

    // Move the addressed bytes down to bit 0 and clear the rest
    function automatic logic [DW-1:0] align_rdata(input logic [DW-1:0] data,
                                                  input logic [2:0] offset,
                                                  input acc_size_e size);
        logic [DW-1:0] shifted;
        shifted = data >> {offset, 3'b000};
        case (size)
            SZ_BYTE: return DW'(shifted[7:0]);
            SZ_HALF: return DW'(shifted[15:0]);
            SZ_WORD: return DW'(shifted[31:0]);
            default: return shifted;
        endcase
    endfunction

    assign pop_o   = (state_q == ST_IDLE) && !empty_i;
    assign aw_fire = aw_valid_o && aw_ready_i;
    assign w_fire  = w_valid_o && w_ready_i;
    assign r_fire  = r_valid_i && r_ready_o;
    assign b_fire  = b_valid_i && b_ready_o;

    always_comb begin
        ax.id    = id_q;
        ax.addr  = req_q.addr;
        ax.len   = 8'd0;                            // Single beat
        ax.size  = {1'b0, req_q.size};
        ax.burst = BURST_INCR;
    end

    assign aw_o       = ax;
    assign ar_o       = ax;
    assign w_o.data   = req_q.wdata;
    assign w_o.strb   = req_q.wstrb;
    assign w_o.last   = 1'b1;
    assign ar_valid_o = (state_q == ST_AR);
    assign aw_valid_o = (state_q == ST_AW_W) && !aw_done_q;
    assign w_valid_o  = (state_q == ST_AW_W) && !w_done_q;
    assign r_ready_o  = (state_q == ST_R);
    assign b_ready_o  = (state_q == ST_B);

    always_ff @(posedge clock) begin
        if (reset_i) begin
            state_q      <= ST_IDLE;
            id_cnt_q     <= '0;
            aw_done_q    <= 1'b0;
            w_done_q     <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (pop_o) begin
                        id_cnt_q  <= id_cnt_q + 1'b1;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= (req_i.op == OP_READ) ? ST_AR : ST_AW_W;
                    end
                end
                ST_AR: begin
                    if (ar_ready_i) begin
                        state_q <= ST_R;
                    end
                end
                ST_R: begin
                    if (r_fire) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= ST_IDLE;
                    end
                end
                ST_AW_W: begin
                    if (aw_fire) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done_q <= 1'b1;
                    end
                    if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
                        state_q <= ST_B;
                    end
                end
                ST_B: begin
                    if (b_fire) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (pop_o) begin
            req_q <= req_i;
            id_q  <= id_cnt_q;
        end
        if (r_fire) begin
            rdata_q <= align_rdata(r_i.data, req_q.addr[2:0], req_q.size);
            resp_q  <= (r_i.id != id_q || !r_i.last) ? RESP_SLVERR : r_i.resp;
        end else if (b_fire) begin
            rdata_q <= '0;                          // Writes return no data
            resp_q  <= (b_i.id != id_q) ? RESP_SLVERR : b_i.resp;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign rdata_o      = rdata_q;
    assign resp_o       = resp_q;

endmodule

/* hdl/axi_settings.svh */
`ifndef AXI_SETTINGS_SVH
`define AXI_SETTINGS_SVH

// Bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH   4
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// Request queue between issue logic and bus master
`define REQ_FIFO_DEPTH 4

`endif

/* hdl/mem_req_issue.sv */
`timescale 1ns/100ps
`include "axi_settings.svh"

module mem_req_issue import axi_pkg::*; (
    input  logic                         clock,
    input  logic                         reset_i,
    input  logic                         rd_valid_i,
    input  logic                         wr_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   addr_i,
    input  acc_size_e                    size_i,
    input  logic [`AXI_DATA_WIDTH-1:0]   wdata_i,
    input  logic                         full_i,
    output logic                         ready_o,
    output logic                         push_o,
    output mem_req_t                     req_o
);

    logic                         req_valid;
    logic [2:0]                   offset;
    logic [`AXI_STRB_WIDTH-1:0]   base_strb;
    mem_req_t                     new_req;
    logic                         hold_valid_q;
    mem_req_t                     hold_q;

    assign req_valid = rd_valid_i | wr_valid_i;
    assign offset    = addr_i[2:0];

    always_comb begin
        case (size_i)
            SZ_BYTE: base_strb = 8'h01;
            SZ_HALF: base_strb = 8'h03;
            SZ_WORD: base_strb = 8'h0f;
            default: base_strb = 8'hff;
        endcase
    end

    always_comb begin
        new_req.op    = rd_valid_i ? OP_READ : OP_WRITE;  // Read wins
        new_req.size  = size_i;
        new_req.addr  = addr_i;
        new_req.wdata = wdata_i << {offset, 3'b000};
        new_req.wstrb = base_strb << offset;
    end

    // One request can wait here while the queue is full
    always_ff @(posedge clock) begin
        if (reset_i) begin
            hold_valid_q <= 1'b0;
        end else if (hold_valid_q) begin
            if (!full_i) begin
                hold_valid_q <= 1'b0;               // Drained into queue
            end
        end else if (req_valid && full_i) begin
            hold_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!hold_valid_q && req_valid && full_i) begin
            hold_q <= new_req;
        end
    end

    assign ready_o = !full_i && !hold_valid_q;
    assign push_o  = !reset_i && !full_i && (hold_valid_q || req_valid);
    assign req_o   = hold_valid_q ? hold_q : new_req;

endmodule

/* hdl/req_fifo.sv */
`timescale 1ns/100ps
`include "axi_settings.svh"

module req_fifo import axi_pkg::*; #(
    parameter int depth = `REQ_FIFO_DEPTH
) (
    input  logic       clock,
    input  logic       reset_i,
    input  logic       push_i,
    input  mem_req_t   data_i,
    input  logic       pop_i,
    output mem_req_t   data_o,
    output logic       empty_o,
    output logic       full_o
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    mem_req_t               mem_q [depth];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [CNT_W-1:0]       count_q;
    logic                   do_push;
    logic                   do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(depth));

    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);  // Full is fine if a pop frees a slot

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o = mem_q[rd_ptr_q];                // Head record

endmodule

/* hdl/sim_top.sv */
`timescale 1ns/100ps
`include "axi_settings.svh"

module sim_top import axi_pkg::*; (
    input  logic                         clock,
    input  logic                         reset_i,
    input  logic                         cpu_rd_valid_i,
    input  logic                         cpu_wr_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   cpu_addr_i,
    input  acc_size_e                    cpu_size_i,   // 00:1B 01:2B 10:4B 11:8B
    input  logic [`AXI_DATA_WIDTH-1:0]   cpu_wdata_i,
    output logic                         cpu_ready_o,
    output logic                         cpu_resp_valid_o,
    output logic [`AXI_DATA_WIDTH-1:0]   cpu_rdata_o,
    output axi_resp_e                    cpu_resp_o,
    output axi_ax_t                      aw_o,
    output logic                         aw_valid_o,
    input  logic                         aw_ready_i,
    output axi_w_t                       w_o,
    output logic                         w_valid_o,
    input  logic                         w_ready_i,
    input  axi_b_t                       b_i,
    input  logic                         b_valid_i,
    output logic                         b_ready_o,
    output axi_ax_t                      ar_o,
    output logic                         ar_valid_o,
    input  logic                         ar_ready_i,
    input  axi_r_t                       r_i,
    input  logic                         r_valid_i,
    output logic                         r_ready_o
);

    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    mem_req_t   issue_req;
    mem_req_t   head_req;

    mem_req_issue u_issue (
        .clock      (clock          ),
        .reset_i    (reset_i        ),
        .rd_valid_i (cpu_rd_valid_i ),
        .wr_valid_i (cpu_wr_valid_i ),
        .addr_i     (cpu_addr_i     ),
        .size_i     (cpu_size_i     ),
        .wdata_i    (cpu_wdata_i    ),
        .full_i     (full           ),
        .ready_o    (cpu_ready_o    ),
        .push_o     (push           ),
        .req_o      (issue_req      )
    );

    req_fifo #(
        .depth      (`REQ_FIFO_DEPTH)
    ) u_fifo (
        .clock      (clock          ),
        .reset_i    (reset_i        ),
        .push_i     (push           ),
        .data_i     (issue_req      ),
        .pop_i      (pop            ),
        .data_o     (head_req       ),
        .empty_o    (empty          ),
        .full_o     (full           )
    );

    axi_rw_master u_master (
        .clock        (clock            ),
        .reset_i      (reset_i          ),
        .req_i        (head_req         ),
        .empty_i      (empty            ),
        .pop_o        (pop              ),
        .aw_o         (aw_o             ),
        .aw_valid_o   (aw_valid_o       ),
        .aw_ready_i   (aw_ready_i       ),
        .w_o          (w_o              ),
        .w_valid_o    (w_valid_o        ),
        .w_ready_i    (w_ready_i        ),
        .b_i          (b_i              ),
        .b_valid_i    (b_valid_i        ),
        .b_ready_o    (b_ready_o        ),
        .ar_o         (ar_o             ),
        .ar_valid_o   (ar_valid_o       ),
        .ar_ready_i   (ar_ready_i       ),
        .r_i          (r_i              ),
        .r_valid_i    (r_valid_i        ),
        .r_ready_o    (r_ready_o        ),
        .resp_valid_o (cpu_resp_valid_o ),
        .rdata_o      (cpu_rdata_o      ),
        .resp_o       (cpu_resp_o       )
    );

endmodule

/* sim_top.f */
+incdir+hdl
hdl/axi_pkg.sv
hdl/mem_req_issue.sv
hdl/req_fifo.sv
hdl/axi_rw_master.sv
hdl/sim_top.sv
tests/tb_clock_gen.sv
tests/sim_top_asserts.sv
tests/tb_sim_top.sv

/* tests/sim_top_asserts.sv */
`timescale 1ns/100ps

module sim_top_asserts import axi_pkg::*; (
    input logic          clock,
    input logic          reset_i,
    input master_state_e state_q,
    input logic          empty_i,
    input axi_ax_t       aw_o,
    input logic          aw_valid_o,
    input logic          aw_ready_i,
    input axi_w_t        w_o,
    input logic          w_valid_o,
    input logic          w_ready_i,
    input axi_ax_t       ar_o,
    input logic          ar_valid_o,
    input logic          ar_ready_i,
    input logic          resp_valid_o
);

    aw_hold: assert property (@(posedge clock) disable iff (reset_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else $error("AW valid dropped or payload changed before its transfer");

    w_hold: assert property (@(posedge clock) disable iff (reset_i)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
        else $error("W valid dropped or payload changed before its transfer");

    ar_hold: assert property (@(posedge clock) disable iff (reset_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else $error("AR valid dropped or payload changed before its transfer");

    resp_pulse: assert property (@(posedge clock) disable iff (reset_i)
        resp_valid_o |=> !resp_valid_o)
        else $error("Core response pulse longer than one cycle");

    // Pop from idle starts AR, or AW and W together, in the next cycle
    pop_start: assert property (@(posedge clock) disable iff (reset_i)
        (state_q == ST_IDLE) && !empty_i |=> ar_valid_o || (aw_valid_o && w_valid_o))
        else $error("Popped request did not start its AXI transaction in the next cycle");

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 16
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #(period_ns / 2.0) clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

/* tests/tb_sim_top.sv */
`timescale 1ns/100ps
`include "axi_settings.svh"

module tb_sim_top import axi_pkg::*; ();

    typedef struct packed {
        logic [63:0] data;
        axi_resp_e   resp;
    } exp_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [2:0]  size;
    } bus_exp_t;

    logic clock, reset;
    logic cpu_rd_valid, cpu_wr_valid, cpu_ready, cpu_resp_valid;
    logic [31:0] cpu_addr;
    acc_size_e cpu_size, size;
    logic [63:0] cpu_wdata, cpu_rdata;
    axi_resp_e cpu_resp;
    axi_ax_t aw, ar, awc, arc;
    axi_w_t w, wc;
    axi_b_t b;
    axi_r_t r;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;

    logic [63:0] bus_mem [256];
    logic [7:0]  shadow [2048];
    exp_t        exp_q [$];
    exp_t        exp_head;
    bus_exp_t    bus_q [$];
    logic [3:0]  last_id;
    logic        id_seen;
    logic [31:0] rng_stim = 32'h8a56;
    logic [31:0] rng_bus  = 32'h8a56;
    int errors, checks, tests, n_issued, cycles, test_err0;
    logic ready_low_seen;

    tb_clock_gen u_clk (.clock_o(clock), .reset_o(reset));

    sim_top u_dut (
        .clock(clock), .reset_i(reset),
        .cpu_rd_valid_i(cpu_rd_valid), .cpu_wr_valid_i(cpu_wr_valid),
        .cpu_addr_i(cpu_addr), .cpu_size_i(cpu_size), .cpu_wdata_i(cpu_wdata),
        .cpu_ready_o(cpu_ready), .cpu_resp_valid_o(cpu_resp_valid),
        .cpu_rdata_o(cpu_rdata), .cpu_resp_o(cpu_resp),
        .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
        .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
        .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready),
        .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
        .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready)
    );

    bind axi_rw_master sim_top_asserts u_asserts (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ ((a >> 8) * 8'h3b));   // Every address bit matters
    endfunction

    // Expected core response from the byte-level view of memory
    function automatic exp_t ref_result(input mem_op_e op, input logic [31:0] addr,
                                        input acc_size_e sz);
        exp_t e;
        e.data = '0;
        e.resp = RESP_OKAY;
        if (op == OP_WRITE) return e;
        if (addr[31]) begin
            e.resp = RESP_SLVERR;
            return e;
        end
        for (int i = 0; i < (1 << sz); i++) e.data[8*i +: 8] = shadow[addr[10:0] + i];
        return e;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input acc_size_e sz,
                                input logic [63:0] data);
        for (int i = 0; i < (1 << sz); i++) shadow[addr[10:0] + i] = data[8*i +: 8];
    endtask

    task automatic issue(input mem_op_e op, input logic [31:0] addr, input acc_size_e sz,
                         input logic [63:0] data);
        bus_exp_t be;
        be.op   = op;
        be.addr = addr;
        be.size = 3'($clog2(1 << sz));                 // AxSIZE is log2 of the byte count
        bus_q.push_back(be);
        exp_q.push_back(ref_result(op, addr, sz));
        if (op == OP_WRITE) shadow_write(addr, sz, data);
        n_issued++;
        @(negedge clock);
        while (!cpu_ready) begin
            ready_low_seen = 1'b1;
            @(posedge clock);
            cpu_rd_valid <= 1'b0;
            cpu_wr_valid <= 1'b0;
            @(negedge clock);
        end
        @(posedge clock);
        cpu_rd_valid <= (op == OP_READ);
        cpu_wr_valid <= (op == OP_WRITE);
        cpu_addr     <= addr;
        cpu_size     <= sz;
        cpu_wdata    <= data;
    endtask

    task automatic drain();
        @(posedge clock);
        cpu_rd_valid <= 1'b0;
        cpu_wr_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clock);
        repeat (4) @(posedge clock);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s expected %0b got %0b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Address channel fields against the oldest core request
    task automatic inspect_addr_channel(input string ch, input axi_ax_t ax,
                                        input mem_op_e op);
        bus_exp_t be;
        checks++;
        assert (bus_q.size() != 0) else begin
            $display("Transaction on %s at %0t has no matching core request", ch, $time);
            errors++;
        end
        if (bus_q.size() != 0) begin
            be = bus_q.pop_front();
            compare_value({ch, " request type"}, op, be.op);
            compare_value({ch, ".addr"}, ax.addr, be.addr);
            compare_value({ch, ".size"}, ax.size, be.size);
            compare_value({ch, ".len"}, ax.len, 8'd0);
            compare_value({ch, ".burst"}, ax.burst, 2'b01);   // INCR
        end
        if (id_seen) begin
            compare_value({ch, ".id"}, ax.id, 4'(last_id + 1'b1));
        end
        last_id = ax.id;
        id_seen = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_err0);
        test_err0 = errors;
    endtask

    function automatic logic [31:0] rand_addr(input logic [31:0] rv, input acc_size_e sz);
        logic [2:0] off;
        off = rv[2:0] & ~3'((1 << sz) - 1);
        return {21'b0, rv[15:8], off};
    endfunction

    task automatic bus_read();
        int d;
        rng_bus = xorshift(rng_bus);
        d = rng_bus % 4;
        repeat (d) @(posedge clock);
        ar_ready <= 1'b1;
        @(posedge clock);
        ar_ready <= 1'b0;
        arc = ar;
        inspect_addr_channel("ar_o", arc, OP_READ);
        rng_bus = xorshift(rng_bus);
        d = rng_bus % 4;
        repeat (d) @(posedge clock);
        r.id   <= arc.id;
        r.last <= 1'b1;
        r.resp <= arc.addr[31] ? RESP_SLVERR : RESP_OKAY;
        r.data <= arc.addr[31] ? 64'h0 : bus_mem[arc.addr[10:3]];
        r_valid <= 1'b1;
        do @(posedge clock); while (!r_ready);
        r_valid <= 1'b0;
    endtask

    task automatic bus_write();
        int da, dw, cnt;
        logic aw_got, w_got;
        rng_bus = xorshift(rng_bus);
        da = rng_bus % 4;
        dw = (rng_bus >> 8) % 4;
        aw_got = 1'b0;
        w_got = 1'b0;
        cnt = 0;
        while (!(aw_got && w_got)) begin
            aw_ready <= !aw_got && cnt >= da;
            w_ready  <= !w_got && cnt >= dw;
            @(posedge clock);
            if (aw_valid && aw_ready) begin
                aw_got = 1'b1;
                awc = aw;
            end
            if (w_valid && w_ready) begin
                w_got = 1'b1;
                wc = w;
            end
            cnt++;
        end
        aw_ready <= 1'b0;
        w_ready  <= 1'b0;
        inspect_addr_channel("aw_o", awc, OP_WRITE);
        compare_value("w_o.last", wc.last, 1'b1);
        for (int i = 0; i < 8; i++)
            if (wc.strb[i]) bus_mem[awc.addr[10:3]][8*i +: 8] = wc.data[8*i +: 8];
        rng_bus = xorshift(rng_bus);
        repeat (rng_bus % 4) @(posedge clock);
        b.id    <= awc.id;
        b.resp  <= RESP_OKAY;
        b_valid <= 1'b1;
        do @(posedge clock); while (!b_ready);
        b_valid <= 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 2048; i++) shadow[i] = fill_byte(i);
        for (int i = 0; i < 256; i++)
            for (int j = 0; j < 8; j++) bus_mem[i][8*j +: 8] = fill_byte(i * 8 + j);
        @(negedge reset);
        forever begin
            @(posedge clock);
            if (ar_valid) bus_read();
            else if (aw_valid || w_valid) bus_write();
        end
    end

    // Compare each response pulse with the oldest expectation
    always @(posedge clock) begin
        if (!reset && cpu_resp_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("Response at %0t arrived with no request pending", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                checks += 2;
                assert (cpu_rdata === exp_head.data) else begin
                    $display("FAILED t=%0t cpu_rdata_o expected %h got %h",
                             $time, exp_head.data, cpu_rdata);
                    errors++;
                end
                assert (cpu_resp === exp_head.resp) else begin
                    $display("FAILED t=%0t cpu_resp_o expected %s got %s",
                             $time, exp_head.resp.name(), cpu_resp.name());
                    errors++;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= 200 * (n_issued + 1) + 64) begin
            @(posedge clock);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles with %0d requests issued",
                 cycles, n_issued);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [63:0] d;
        cpu_rd_valid = 0;
        cpu_wr_valid = 0;
        cpu_addr = 0;
        cpu_size = SZ_BYTE;
        cpu_wdata = 0;
        aw_ready = 0;
        w_ready = 0;
        ar_ready = 0;
        b = '0;
        b_valid = 0;
        r = '0;
        r_valid = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        n_issued = 0;
        test_err0 = 0;
        ready_low_seen = 0;
        id_seen = 0;
        last_id = '0;
        @(negedge reset);
        @(negedge clock);
        check_bit("cpu_resp_valid_o", cpu_resp_valid, 1'b0);
        check_bit("aw_valid_o", aw_valid, 1'b0);
        check_bit("w_valid_o", w_valid, 1'b0);
        check_bit("ar_valid_o", ar_valid, 1'b0);
        check_bit("b_ready_o", b_ready, 1'b0);
        check_bit("r_ready_o", r_ready, 1'b0);
        check_bit("cpu_ready_o", cpu_ready, 1'b1);
        end_test("reset state");

        for (int s = 0; s < 4; s++)
            for (int o = 0; o < 8; o += (1 << s)) begin
                rng_stim = xorshift(rng_stim);
                d = {rng_stim, xorshift(rng_stim)};
                issue(OP_WRITE, 32'h400 + ((s * 8 + o) << 3) + o, acc_size_e'(s), d);
            end
        for (int s = 0; s < 4; s++)
            for (int o = 0; o < 8; o += (1 << s))
                issue(OP_READ, 32'h400 + ((s * 8 + o) << 3), SZ_DWORD, '0);
        drain();
        end_test("write strobes");

        for (int i = 0; i < 24; i++) begin
            rng_stim = xorshift(rng_stim);
            size = acc_size_e'(i % 3);
            issue(OP_READ, rand_addr(rng_stim, size), size, '0);
        end
        drain();
        end_test("sub-word reads");

        ready_low_seen = 1'b0;
        for (int i = 0; i < 40; i++) begin
            rng_stim = xorshift(rng_stim);
            size = acc_size_e'(rng_stim[17:16]);
            a = rand_addr(rng_stim, size);
            rng_stim = xorshift(rng_stim);
            d = {rng_stim, ~rng_stim};
            issue(rng_stim[20] ? OP_WRITE : OP_READ, a, size, d);
        end
        drain();
        checks++;
        assert (ready_low_seen) else begin
            $display("Queue never filled, cpu_ready_o stayed high during the burst");
            errors++;
        end
        end_test("random burst");

        issue(OP_READ, 32'h8000_0010, SZ_DWORD, '0);
        issue(OP_WRITE, 32'h0000_0010, SZ_WORD, 64'h1234_5678);
        issue(OP_READ, 32'h8000_0123, SZ_BYTE, '0);
        issue(OP_READ, 32'h0000_0010, SZ_DWORD, '0);
        drain();
        end_test("slave error");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
